/* verilog.f */
+incdir+hdl
hdl/ooo_pkg.sv
hdl/issue_entry.sv
hdl/issue_buffer.sv
hdl/ready_table.sv
hdl/phys_regfile.sv
hdl/exec_unit.sv
hdl/issue_ctrl.sv
hdl/ooo_core_top.sv
verification/ooo_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module ooo_tb
./obj_dir/Vooo_tb > sim.log 2>&1
cat sim.log

if grep -qx "Simulation finished: PASS" sim.log; then
    exit 0
fi
exit 1

/* verification/ooo_tb.sv */
`include "ooo_consts.svh"

module ooo_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import ooo_pkg::*;

    localparam int n_li           = 32;
    localparam int n_chain        = 64;
    localparam int n_rand         = 400;
    localparam int n_total        = n_li + n_chain + n_rand;
    localparam int timeout_cycles = n_total * 40 + 1000;

    logic       clk = 1'b0;
    logic       rst;
    op_bundle_t din;
    push_ct_t   din_valid_ct;
    push_ct_t   din_ready_ct;
    wb_t        complete;
    logic       idle;

    integer      seed = 32'h4e54aebd;
    int          value_errors = 0;
    int          other_errors = 0;
    int          inflight = 0;
    int          partial_accepts = 0;
    word_t       exp_val [`PREG_COUNT];
    renamed_op_t op_of   [`PREG_COUNT];
    bit          pending [`PREG_COUNT];
    int          readers [`PREG_COUNT];
    int          recent  [$];
    renamed_op_t offer   [$];

    ooo_core_top dut_i (
        .clk          (clk),
        .rst          (rst),
        .din          (din),
        .din_valid_ct (din_valid_ct),
        .din_ready_ct (din_ready_ct),
        .complete     (complete),
        .idle         (idle)
    );

    always #5 clk = ~clk;

    // ##########################################################
    // reference model and stimulus helpers
    // ##########################################################

    function automatic word_t eval_op(opcode_e op, word_t a, word_t b, logic [7:0] imm);
        case (op)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_and:  return a & b;
            op_xor:  return a ^ b;
            default: return word_t'(imm);
        endcase
    endfunction

    function automatic int rand_below(int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // a destination also needs no outstanding reader
    function automatic int find_reg(bit for_dst);
        int start;
        int r;
        start = rand_below(`PREG_COUNT);
        for (int k = 0; k < `PREG_COUNT; k++) begin
            r = (start + k) % `PREG_COUNT;
            if (!pending[r] && (!for_dst || readers[r] == 0)) begin
                return r;
            end
        end
        return -1;
    endfunction

    // chains lean hard on the newest results
    function automatic int pick_src(int mode);
        if (recent.size() > 0 && rand_below(4) < (mode == 1 ? 3 : 2)) begin
            return recent[rand_below(recent.size())];
        end
        return rand_below(`PREG_COUNT);
    endfunction

    function automatic bit gen_op(int mode);
        renamed_op_t op;
        int s1;
        int s2;
        int d;
        bit is_li;
        is_li = (mode == 0) || (mode == 2 && rand_below(4) == 0);
        s1 = is_li ? find_reg(1'b0) : pick_src(mode);
        s2 = is_li ? find_reg(1'b0) : pick_src(mode);
        if (s1 < 0 || s2 < 0) begin
            return 1'b0;
        end
        readers[s1]++;
        readers[s2]++;
        d = find_reg(1'b1);
        if (d < 0) begin
            readers[s1]--;
            readers[s2]--;
            return 1'b0;
        end
        op.opcode = is_li ? op_li : opcode_e'(rand_below(4));
        op.dst    = preg_t'(d);
        op.src1   = preg_t'(s1);
        op.src2   = preg_t'(s2);
        op.imm    = 8'(rand_below(256));
        exp_val[d] = eval_op(op.opcode, exp_val[s1], exp_val[s2], op.imm);
        op_of[d]   = op;
        pending[d] = 1'b1;
        inflight++;
        recent.push_back(d);
        if (recent.size() > 4) begin
            void'(recent.pop_front());
        end
        offer.push_back(op);
        return 1'b1;
    endfunction

    // din_ready_ct depends only on slot state, so it holds until the next edge
    task automatic drive_offer();
        int ready;
        int cnt;
        int acc;
        ready = int'(din_ready_ct);
        cnt   = offer.size();
        if (ready > `PUSH_WIDTH) begin
            $display("[ERROR] %0t din_ready_ct: expected <= %0d, got %0d", $time,
                     `PUSH_WIDTH, ready);
            other_errors++;
        end
        din = '0;
        for (int i = 0; i < cnt; i++) begin
            din[i] = offer[i];
        end
        din_valid_ct = push_ct_t'(cnt);
        acc = (cnt < ready) ? cnt : ready;
        if (acc < cnt) begin
            partial_accepts++;
        end
        repeat (acc) void'(offer.pop_front());
    endtask

    task automatic check_idle();
        if (idle !== 1'b1) begin
            $display("[ERROR] %0t idle: expected 1, got %b", $time, idle);
            value_errors++;
        end
        if (din_ready_ct !== push_ct_t'(`PUSH_WIDTH)) begin
            $display("[ERROR] %0t din_ready_ct: expected %0d, got %0d", $time,
                     `PUSH_WIDTH, din_ready_ct);
            value_errors++;
        end
        if (complete.valid !== 1'b0) begin
            $display("[ERROR] %0t complete.valid: expected 0, got %b", $time, complete.valid);
            value_errors++;
        end
    endtask

    // accepted operations that have not completed keep the core busy
    task automatic check_busy();
        if (inflight > offer.size() && idle !== 1'b0) begin
            $display("[ERROR] %0t idle: expected 0, got %b", $time, idle);
            value_errors++;
        end
    endtask

    task automatic run_phase(input int mode, input int n_ops);
        int made;
        made = 0;
        while (made < n_ops || offer.size() > 0) begin
            check_busy();
            while (made < n_ops && offer.size() < `PUSH_WIDTH && gen_op(mode)) begin
                made++;
            end
            drive_offer();
            @(negedge clk);
        end
        din_valid_ct = '0;
        din = '0;
        while (inflight > 0) begin
            check_busy();
            @(negedge clk);
        end
        repeat (2) @(negedge clk);
        check_idle();
    endtask

    // ##########################################################
    // completion checker
    // ##########################################################

    always @(posedge clk) begin : completion_check
        int d;
        renamed_op_t op;
        #1;
        if (!rst && complete.valid) begin
            d = int'(complete.dst);
            if (d >= `PREG_COUNT || !pending[d]) begin
                $display("completion at %0t for register %0d with no operation in flight",
                         $time, d);
                other_errors++;
            end else begin
                op = op_of[d];
                if (pending[op.src1] || pending[op.src2]) begin
                    $display("p%0d completed at %0t before the producer of a source", d, $time);
                    other_errors++;
                end
                if (complete.value !== exp_val[d]) begin
                    $display("[ERROR] %0t complete.value for p%0d: expected %h, got %h",
                             $time, d, exp_val[d], complete.value);
                    value_errors++;
                end
                readers[op.src1]--;
                readers[op.src2]--;
                pending[d] = 1'b0;
                inflight--;
            end
        end
    end

    initial begin
        repeat (timeout_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, %0d operations still in flight",
                 timeout_cycles, inflight);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        for (int r = 0; r < `PREG_COUNT; r++) begin
            exp_val[r] = '0;
            pending[r] = 1'b0;
            readers[r] = 0;
        end
        rst = 1'b1;
        din = '0;
        din_valid_ct = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_idle();
        run_phase(0, n_li);
        run_phase(1, n_chain);
        run_phase(2, n_rand);
        if (partial_accepts == 0) begin
            $display("no offer was ever cut short by din_ready_ct");
            other_errors++;
        end
        $display("errors: value=%0d other=%0d (partial accepts seen: %0d)",
                 value_errors, other_errors, partial_accepts);
        if (value_errors + other_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* hdl/ooo_core_top.sv */
`include "ooo_consts.svh"

module ooo_core_top (
    input  logic                clk,
    input  logic                rst,
    input  ooo_pkg::op_bundle_t din,
    input  ooo_pkg::push_ct_t   din_valid_ct,
    output ooo_pkg::push_ct_t   din_ready_ct,
    output ooo_pkg::wb_t        complete,
    output logic                idle
);
    import ooo_pkg::*;

    push_ct_t               free_ct;
    push_ct_t               accept_ct;
    renamed_op_t            issue_op;
    logic                   issue_valid;
    preg_t                  src1;
    preg_t                  src2;
    word_t                  rdata1;
    word_t                  rdata2;
    wb_t                    wb;
    logic [`PREG_COUNT-1:0] done_flags;

    issue_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .din_valid_ct (din_valid_ct),
        .free_ct      (free_ct),
        .issue_valid  (issue_valid),
        .wb_valid     (wb.valid),
        .accept_ct    (accept_ct),
        .idle         (idle)
    );

    issue_buffer u_buffer (
        .clk          (clk),
        .rst          (rst),
        .din          (din),
        .accept_ct    (accept_ct),
        .done_flags   (done_flags),
        .din_ready_ct (din_ready_ct),
        .free_ct      (free_ct),
        .issue_op     (issue_op),
        .issue_valid  (issue_valid)
    );

    ready_table u_ready (
        .clk        (clk),
        .rst        (rst),
        .din        (din),
        .accept_ct  (accept_ct),
        .wb         (wb),
        .done_flags (done_flags)
    );

    phys_regfile u_regfile (
        .clk    (clk),
        .rst    (rst),
        .src1   (src1),
        .src2   (src2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .wb     (wb)
    );

    exec_unit u_exec (
        .clk         (clk),
        .rst         (rst),
        .issue_op    (issue_op),
        .issue_valid (issue_valid),
        .src1        (src1),
        .src2        (src2),
        .rdata1      (rdata1),
        .rdata2      (rdata2),
        .wb          (wb)
    );

    assign complete = wb;

endmodule

/* hdl/issue_ctrl.sv */
`include "ooo_consts.svh"

module issue_ctrl (
    input  logic              clk,
    input  logic              rst,
    input  ooo_pkg::push_ct_t din_valid_ct,
    input  ooo_pkg::push_ct_t free_ct,
    input  logic              issue_valid,
    input  logic              wb_valid,
    output ooo_pkg::push_ct_t accept_ct,
    output logic              idle
);
    import ooo_pkg::*;

    // slots plus the two exec stages
    localparam int occ_max = `IQ_ELEMENTS + 2;
    localparam int occ_w   = $clog2(occ_max + 1);

    ctrl_state_e      state_q;
    ctrl_state_e      state_d;
    logic [occ_w-1:0] occ_q;
    logic [occ_w-1:0] occ_d;

    assign accept_ct = (din_valid_ct < free_ct) ? din_valid_ct : free_ct;

    // an op counts from acceptance until its writeback
    assign occ_d = occ_q + occ_w'(accept_ct) - occ_w'(wb_valid);

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle:   if (accept_ct != '0) state_d = st_active;
            st_active: if (occ_d == '0) state_d = st_idle;
            default:   state_d = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= st_idle;
            occ_q   <= '0;
        end else begin
            state_q <= state_d;
            occ_q   <= occ_d;
        end
    end

    assign idle = (state_q == st_idle);

    a_accept_le_free: assert property (
        @(posedge clk) disable iff (rst) accept_ct <= free_ct
    );
    a_occ_bound: assert property (
        @(posedge clk) disable iff (rst) occ_q <= occ_max
    );
    // nothing issues from an empty core
    a_issue_outstanding: assert property (
        @(posedge clk) disable iff (rst) issue_valid |-> occ_q != '0
    );

endmodule

/* hdl/exec_unit.sv */
module exec_unit (
    input  logic                 clk,
    input  logic                 rst,
    input  ooo_pkg::renamed_op_t issue_op,
    input  logic                 issue_valid,
    output ooo_pkg::preg_t       src1,
    output ooo_pkg::preg_t       src2,
    input  ooo_pkg::word_t       rdata1,
    input  ooo_pkg::word_t       rdata2,
    output ooo_pkg::wb_t         wb
);
    import ooo_pkg::*;

    logic        s1_valid;
    renamed_op_t s1_op;
    word_t       s1_a;
    word_t       s1_b;
    word_t       result;
    logic        wb_valid_q;
    preg_t       wb_dst_q;
    word_t       wb_value_q;

    assign src1 = issue_op.src1;
    assign src2 = issue_op.src2;

    // ##########################################################
    // stage 1, operand read
    // ##########################################################

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_op <= issue_op;
        s1_a  <= rdata1;
        s1_b  <= rdata2;
    end

    // ##########################################################
    // stage 2, execute and writeback
    // ##########################################################

    always_comb begin
        case (s1_op.opcode)
            op_add:  result = s1_a + s1_b;
            op_sub:  result = s1_a - s1_b;
            op_and:  result = s1_a & s1_b;
            op_xor:  result = s1_a ^ s1_b;
            op_li:   result = word_t'(s1_op.imm);
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid_q <= 1'b0;
        end else begin
            wb_valid_q <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        wb_dst_q   <= s1_op.dst;
        wb_value_q <= result;
    end

    assign wb = '{valid: wb_valid_q, dst: wb_dst_q, value: wb_value_q};

endmodule

/* hdl/phys_regfile.sv */
`include "ooo_consts.svh"

module phys_regfile (
    input  logic                 clk,
    input  logic                 rst,
    input  ooo_pkg::preg_t       src1,
    input  ooo_pkg::preg_t       src2,
    output ooo_pkg::word_t       rdata1,
    output ooo_pkg::word_t       rdata2,
    input  ooo_pkg::wb_t         wb
);
    import ooo_pkg::*;

    word_t regs [`PREG_COUNT];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `PREG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid) begin
            regs[wb.dst] <= wb.value;
        end
    end

    // no bypass, a consumer issues only after the write edge
    assign rdata1 = regs[src1];
    assign rdata2 = regs[src2];

endmodule

/* hdl/ready_table.sv */
`include "ooo_consts.svh"

module ready_table (
    input  logic                    clk,
    input  logic                    rst,
    input  ooo_pkg::op_bundle_t     din,
    input  ooo_pkg::push_ct_t       accept_ct,
    input  ooo_pkg::wb_t            wb,
    output logic [`PREG_COUNT-1:0]  done_flags
);

    logic [`PREG_COUNT-1:0] flags_q;
    logic [`PREG_COUNT-1:0] clear_mask;
    logic [`PREG_COUNT-1:0] set_mask;

    // destinations of this cycle's accepted ops
    always_comb begin
        clear_mask = '0;
        for (int i = 0; i < `PUSH_WIDTH; i++) begin
            if (i < int'(accept_ct)) begin
                clear_mask[din[i].dst] = 1'b1;
            end
        end
    end

    always_comb begin
        set_mask = '0;
        if (wb.valid) begin
            set_mask[wb.dst] = 1'b1;
        end
    end

    // a register handed out again this cycle stays pending
    always_ff @(posedge clk) begin
        if (rst) begin
            flags_q <= '1;
        end else begin
            flags_q <= (flags_q | set_mask) & ~clear_mask;
        end
    end

    assign done_flags = flags_q;

    // writeback only ever lands on a pending register
    a_wb_pending: assert property (
        @(posedge clk) disable iff (rst)
        wb.valid |-> !flags_q[wb.dst]
    );

endmodule

/* hdl/issue_buffer.sv */
`include "ooo_consts.svh"

module issue_buffer (
    input  logic                    clk,
    input  logic                    rst,
    input  ooo_pkg::op_bundle_t     din,
    input  ooo_pkg::push_ct_t       accept_ct,
    input  logic [`PREG_COUNT-1:0]  done_flags,
    output ooo_pkg::push_ct_t       din_ready_ct,
    output ooo_pkg::push_ct_t       free_ct,
    output ooo_pkg::renamed_op_t    issue_op,
    output logic                    issue_valid
);
    import ooo_pkg::*;

    localparam int iq_idx_w   = $clog2(`IQ_ELEMENTS);
    localparam int push_idx_w = $clog2(`PUSH_WIDTH);

    logic [`IQ_ELEMENTS-1:0] avail_mask;
    logic [`IQ_ELEMENTS-1:0] ready_mask;
    logic [`IQ_ELEMENTS-1:0] write_mask;
    logic [`IQ_ELEMENTS-1:0] issue_mask;
    renamed_op_t [`IQ_ELEMENTS-1:0] slot_in;
    renamed_op_t [`IQ_ELEMENTS-1:0] slot_out;
    push_ct_t free_cnt;
    push_ct_t in_idx;
    logic [iq_idx_w-1:0] issue_idx;

    for (genvar i = 0; i < `IQ_ELEMENTS; i++) begin : g_slot
        issue_entry u_entry (
            .clk          (clk),
            .rst          (rst),
            .done_flags   (done_flags),
            .instr        (slot_in[i]),
            .input_valid  (write_mask[i]),
            .output_ready (issue_mask[i]),
            .instr_out    (slot_out[i]),
            .input_ready  (avail_mask[i]),
            .output_valid (ready_mask[i])
        );
    end

    // ##########################################################
    // dispatch side
    // ##########################################################

    // free slots, capped at the push width
    always_comb begin
        free_cnt = '0;
        for (int i = 0; i < `IQ_ELEMENTS; i++) begin
            if (avail_mask[i] && free_cnt < push_ct_t'(`PUSH_WIDTH)) begin
                free_cnt = free_cnt + 1'b1;
            end
        end
    end

    assign din_ready_ct = free_cnt;
    assign free_ct      = free_cnt;

    // oldest accepted op lands in the lowest free slot
    always_comb begin
        in_idx     = '0;
        write_mask = '0;
        slot_in    = '0;
        for (int i = 0; i < `IQ_ELEMENTS; i++) begin
            if (avail_mask[i] && in_idx < accept_ct) begin
                slot_in[i]    = din[in_idx[push_idx_w-1:0]];
                write_mask[i] = 1'b1;
                in_idx        = in_idx + 1'b1;
            end
        end
    end

    // ##########################################################
    // issue side
    // ##########################################################

    // scan downward so the lowest ready slot is the last hit
    always_comb begin
        issue_idx   = '0;
        issue_valid = 1'b0;
        for (int i = `IQ_ELEMENTS - 1; i >= 0; i--) begin
            if (ready_mask[i]) begin
                issue_idx   = iq_idx_w'(i);
                issue_valid = 1'b1;
            end
        end
    end

    always_comb begin
        issue_mask = '0;
        if (issue_valid) begin
            issue_mask[issue_idx] = 1'b1;
        end
    end

    // exec unit never stalls, so the pick leaves this cycle
    assign issue_op = slot_out[issue_idx];

endmodule

/* hdl/issue_entry.sv */
`include "ooo_consts.svh"

module issue_entry (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`PREG_COUNT-1:0]  done_flags,
    input  ooo_pkg::renamed_op_t    instr,
    input  logic                    input_valid,
    input  logic                    output_ready,
    output ooo_pkg::renamed_op_t    instr_out,
    output logic                    input_ready,
    output logic                    output_valid
);
    import ooo_pkg::*;

    logic        valid_q;
    renamed_op_t op_q;

    // slot occupancy
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (input_valid) begin
            valid_q <= 1'b1;
        end else if (output_ready) begin
            valid_q <= 1'b0;
        end
    end

    // payload only moves on a fill
    always_ff @(posedge clk) begin
        if (input_valid) begin
            op_q <= instr;
        end
    end

    assign instr_out   = op_q;
    assign input_ready = !valid_q;

    // wakeup once both producers have written back
    assign output_valid = valid_q
                        && done_flags[op_q.src1]
                        && done_flags[op_q.src2];

    // a slot is filled only when empty and drained only when full
    a_fill_drain_excl: assert property (
        @(posedge clk) disable iff (rst)
        !(input_valid && output_ready)
    );

endmodule

/* hdl/ooo_pkg.sv */
`include "ooo_consts.svh"

package ooo_pkg;

    typedef logic [4:0] preg_t;
    typedef logic [`XLEN-1:0] word_t;
    typedef logic [2:0] push_ct_t;

    typedef enum logic [2:0] {
        op_add = 3'd0,
        op_sub = 3'd1,
        op_and = 3'd2,
        op_xor = 3'd3,
        op_li  = 3'd4
    } opcode_e;

    // op_li still names two sources, both already done
    typedef struct packed {
        opcode_e    opcode;
        preg_t      dst;
        preg_t      src1;
        preg_t      src2;
        logic [7:0] imm;
    } renamed_op_t;

    // entry 0 is the oldest
    typedef renamed_op_t [`PUSH_WIDTH-1:0] op_bundle_t;

    typedef struct packed {
        logic  valid;
        preg_t dst;
        word_t value;
    } wb_t;

    typedef enum logic {
        st_idle   = 1'b0,
        st_active = 1'b1
    } ctrl_state_e;

endpackage

/* hdl/ooo_consts.svh */
`ifndef OOO_CONSTS_SVH
`define OOO_CONSTS_SVH

// physical registers, one done flag each
`define PREG_COUNT 30

// renamed operations offered per cycle
`define PUSH_WIDTH 4

// issue buffer slots
`define IQ_ELEMENTS 8

// datapath width
`define XLEN 16

`endif
